//--- common/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Data word and address width
`define LSU_XLEN 32

// Memory port moves one byte per access
`define LSU_BYTE_W 8

// Immediate offset of I-type loads and S-type stores
`define LSU_OFFSET_W 12

// ROB tag width
// Tag zero marks an empty request and an empty CDB slot
`define LSU_ROB_W 4

`endif

//--- common/lsu_pkg.sv
`default_nettype none

`include "lsu_defs.svh"

package lsu_pkg;

    // funct3 codes of RV32I loads and stores
    // Stores only use the first three
    typedef enum logic [2:0] {
        F3_LB_SB = 3'b000,
        F3_LH_SH = 3'b001,
        F3_LW_SW = 3'b010,
        F3_LBU   = 3'b100,
        F3_LHU   = 3'b101
    } lsu_func3_e;

    // Controller states
    typedef enum logic [1:0] {
        ST_IDLE        = 2'd0,
        ST_LOADING     = 2'd1,
        ST_STORING     = 2'd2,
        ST_LOAD_FINISH = 2'd3  // Waiting on the last data byte
    } lsu_state_e;

    // One data word, seen whole or as little-endian bytes
    typedef union packed {
        logic [`LSU_XLEN-1:0]                              word;
        logic [`LSU_XLEN/`LSU_BYTE_W-1:0][`LSU_BYTE_W-1:0] bytes;
    } lsu_word_u;

endpackage

`default_nettype wire

//--- lsu/lsu_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_ctrl (
    input  wire                          clk_in,
    input  wire                          rst_n,
    input  wire                          req_store,
    input  wire lsu_pkg::lsu_func3_e     req_op,
    input  wire [`LSU_XLEN-1:0]          req_base,
    input  wire [`LSU_OFFSET_W-1:0]      req_offset,
    input  wire [`LSU_ROB_W-1:0]         req_dest,
    input  wire                          mem_success,
    output logic                         recv,
    output logic                         mem_en,
    output logic                         mem_wr,
    output logic [`LSU_XLEN-1:0]         mem_addr,
    output logic [`LSU_ROB_W-1:0]        cdb_rob_id,
    output lsu_pkg::lsu_func3_e          op,
    output logic                         start_store,
    output logic                         start_load,
    output logic                         shift_store,
    output logic                         take_byte,
    output logic                         finish_load,
    output logic                         finish_store
);
    import lsu_pkg::*;

    lsu_state_e              state;
    logic [1:0]              bytes_left;  // Bytes still due after the current one
    logic [1:0]              req_count;
    logic [`LSU_ROB_W-1:0]   cur_tag;
    logic                    load_ok;     // Last cycle's load byte was accepted
    logic                    stale_ack;   // Success now belongs to an older retry
    logic                    req_valid;
    logic                    accept;
    logic                    byte_done;
    logic                    last_byte;
    logic [`LSU_XLEN-1:0]    offset_ext;
    logic [`LSU_XLEN-1:0]    eff_addr;

    assign req_valid = (req_dest != '0);
    assign accept    = (state == ST_IDLE) && req_valid;

    // Base plus sign-extended immediate
    assign offset_ext = {{(`LSU_XLEN-`LSU_OFFSET_W){req_offset[`LSU_OFFSET_W-1]}},
                         req_offset};
    assign eff_addr   = req_base + offset_ext;

    // mem_success answers the access of the previous cycle.
    // The address is retried every cycle, so right after a step the
    // answer still refers to the old byte and is dropped.
    assign byte_done = mem_en && mem_success && !stale_ack;
    assign last_byte = (bytes_left == 2'd0);

    assign mem_wr = (state == ST_STORING);

    // Strobes to the data path, acted on at the next edge
    assign start_store  = accept && req_store;
    assign start_load   = accept && !req_store;
    assign shift_store  = byte_done && (state == ST_STORING);
    assign finish_store = shift_store && last_byte;
    assign take_byte    = load_ok;                       // mem_din carries the byte now
    assign finish_load  = (state == ST_LOAD_FINISH);

    // Byte count minus one per access size
    always_comb begin
        case (req_op)
            F3_LB_SB, F3_LBU: req_count = 2'd0;
            F3_LH_SH, F3_LHU: req_count = 2'd1;
            default:          req_count = 2'd3;  // Word
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            recv       <= 1'b0;
            mem_en     <= 1'b0;
            cdb_rob_id <= '0;
            bytes_left <= 2'd0;
            load_ok    <= 1'b0;
            stale_ack  <= 1'b0;
        end else begin
            recv       <= accept;            // Single cycle, state leaves idle
            cdb_rob_id <= '0;
            stale_ack  <= accept || byte_done;

            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state      <= req_store ? ST_STORING : ST_LOADING;
                        mem_en     <= 1'b1;
                        bytes_left <= req_count;
                        load_ok    <= 1'b0;
                    end
                end

                ST_LOADING: begin
                    load_ok <= byte_done;
                    if (byte_done) begin
                        if (last_byte) begin
                            state  <= ST_LOAD_FINISH;  // Data of this byte still to come
                            mem_en <= 1'b0;
                        end else begin
                            bytes_left <= bytes_left - 2'd1;
                        end
                    end
                end

                ST_LOAD_FINISH: begin
                    state      <= ST_IDLE;
                    load_ok    <= 1'b0;
                    cdb_rob_id <= cur_tag;
                end

                ST_STORING: begin
                    if (byte_done) begin
                        if (last_byte) begin
                            state      <= ST_IDLE;
                            mem_en     <= 1'b0;
                            cdb_rob_id <= cur_tag;
                        end else begin
                            bytes_left <= bytes_left - 2'd1;
                        end
                    end
                end

                default: begin
                    state  <= ST_IDLE;
                    mem_en <= 1'b0;
                end
            endcase
        end
    end

    // Address, tag and func3 of the running access
    always_ff @(posedge clk_in) begin
        if (accept) begin
            mem_addr <= eff_addr;
            cur_tag  <= req_dest;
            op       <= req_op;
        end else if (byte_done && !last_byte) begin
            mem_addr <= mem_addr + `LSU_XLEN'd1;  // Next byte, little endian
        end
    end

endmodule

`default_nettype wire

//--- lsu/lsu_data.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_data (
    input  wire                          clk_in,
    input  wire                          rst_n,
    input  wire [`LSU_XLEN-1:0]          req_data,
    input  wire lsu_pkg::lsu_func3_e     op,
    input  wire                          start_store,
    input  wire                          start_load,
    input  wire                          shift_store,
    input  wire                          take_byte,
    input  wire                          finish_load,
    input  wire                          finish_store,
    input  wire [`LSU_BYTE_W-1:0]        mem_din,
    output logic [`LSU_BYTE_W-1:0]       mem_dout,
    output logic [`LSU_XLEN-1:0]         cdb_value
);
    import lsu_pkg::*;

    lsu_word_u              word_q;      // Store bytes going out or load bytes coming in
    lsu_word_u              filled;      // Buffer with this cycle's byte on top
    lsu_word_u              aligned;
    logic [`LSU_XLEN-1:0]   load_value;

    // Low byte leaves first
    assign mem_dout = word_q.bytes[0];

    assign filled.word = {mem_din, word_q.word[`LSU_XLEN-1:`LSU_BYTE_W]};

    // Bytes arrive at the top, move them down to bit zero by size
    always_comb begin
        case (op)
            F3_LB_SB, F3_LBU: aligned.word = filled.word >> (`LSU_XLEN - `LSU_BYTE_W);
            F3_LH_SH, F3_LHU: aligned.word = filled.word >> (`LSU_XLEN - 2*`LSU_BYTE_W);
            default:          aligned.word = filled.word;
        endcase
    end

    always_comb begin
        case (op)
            F3_LB_SB: begin
                load_value = {{(`LSU_XLEN-`LSU_BYTE_W){aligned.bytes[0][`LSU_BYTE_W-1]}},
                              aligned.bytes[0]};
            end
            F3_LH_SH: begin
                load_value = {{(`LSU_XLEN-2*`LSU_BYTE_W){aligned.bytes[1][`LSU_BYTE_W-1]}},
                              aligned.bytes[1], aligned.bytes[0]};
            end
            F3_LBU: begin
                load_value = {{(`LSU_XLEN-`LSU_BYTE_W){1'b0}}, aligned.bytes[0]};
            end
            F3_LHU: begin
                load_value = {{(`LSU_XLEN-2*`LSU_BYTE_W){1'b0}},
                              aligned.bytes[1], aligned.bytes[0]};
            end
            default: load_value = aligned.word;  // LW
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (start_store) begin
            word_q.word <= req_data;
        end else if (start_load) begin
            word_q.word <= '0;
        end else if (shift_store) begin
            word_q.word <= {{`LSU_BYTE_W{1'b0}}, word_q.word[`LSU_XLEN-1:`LSU_BYTE_W]};
        end else if (take_byte) begin
            word_q <= filled;
        end
    end

    // The last byte is on mem_din during finish_load, so filled already has it
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            cdb_value <= '0;
        end else if (finish_load) begin
            cdb_value <= load_value;
        end else if (finish_store) begin
            cdb_value <= '0;  // Stores carry no result
        end
    end

endmodule

`default_nettype wire

//--- lsu/load_store_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_defs.svh"

module load_store_unit (
    input  wire                          clk_in,
    input  wire                          rst_n,
    input  wire                          req_store,
    input  wire lsu_pkg::lsu_func3_e     req_op,
    input  wire [`LSU_XLEN-1:0]          req_base,
    input  wire [`LSU_XLEN-1:0]          req_data,
    input  wire [`LSU_OFFSET_W-1:0]      req_offset,
    input  wire [`LSU_ROB_W-1:0]         req_dest,
    output wire                          recv,
    input  wire [`LSU_BYTE_W-1:0]        mem_din,
    input  wire                          mem_success,
    output wire [`LSU_XLEN-1:0]          mem_addr,
    output wire [`LSU_BYTE_W-1:0]        mem_dout,
    output wire                          mem_wr,
    output wire                          mem_en,
    output wire [`LSU_ROB_W-1:0]         cdb_rob_id,
    output wire [`LSU_XLEN-1:0]          cdb_value
);
    import lsu_pkg::*;

    wire lsu_func3_e  latched_op;  // func3 of the access in flight
    wire              start_store;
    wire              start_load;
    wire              shift_store;
    wire              take_byte;
    wire              finish_load;
    wire              finish_store;

    lsu_ctrl u_ctrl (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .req_store    (req_store),
        .req_op       (req_op),
        .req_base     (req_base),
        .req_offset   (req_offset),
        .req_dest     (req_dest),
        .mem_success  (mem_success),
        .recv         (recv),
        .mem_en       (mem_en),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .cdb_rob_id   (cdb_rob_id),
        .op           (latched_op),
        .start_store  (start_store),
        .start_load   (start_load),
        .shift_store  (shift_store),
        .take_byte    (take_byte),
        .finish_load  (finish_load),
        .finish_store (finish_store)
    );

    lsu_data u_data (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .req_data     (req_data),
        .op           (latched_op),
        .start_store  (start_store),
        .start_load   (start_load),
        .shift_store  (shift_store),
        .take_byte    (take_byte),
        .finish_load  (finish_load),
        .finish_store (finish_store),
        .mem_din      (mem_din),
        .mem_dout     (mem_dout),
        .cdb_value    (cdb_value)
    );

endmodule

`default_nettype wire

//--- bench/mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module mem_model (
    input  wire         clk_in,
    input  wire         rst_n,
    input  wire         mem_en,
    input  wire         mem_wr,
    input  wire [31:0]  mem_addr,
    input  wire [7:0]   mem_dout,
    output logic [7:0]  mem_din,
    output logic        mem_success
);
    localparam logic [31:0] SEED = 32'h37e22db3;

    logic [7:0]  bytes_q [0:63];
    logic [31:0] lfsr;
    logic [7:0]  read_q;       // Byte read in the access cycle
    logic        grant;
    logic [5:0]  idx;

    assign grant = lfsr[0];    // One LFSR bit per cycle decides acceptance
    assign idx   = mem_addr[5:0];

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    initial begin
        for (int i = 0; i < 64; i++) begin
            bytes_q[i] = 8'(i * 29 + 7);
        end
    end

    always @(posedge clk_in) begin
        if (!rst_n) begin
            lfsr        <= SEED;
            mem_success <= 1'b0;
            read_q      <= 8'h00;
            mem_din     <= 8'h00;
        end else begin
            lfsr        <= lfsr_next(lfsr);
            mem_success <= mem_en && grant;   // Answer for this cycle's access
            read_q      <= bytes_q[idx];
            mem_din     <= read_q;            // Data one cycle after success
            if (mem_en && grant && mem_wr) begin
                bytes_q[idx] <= mem_dout;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/lsu_assert.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_assert (
    input  wire                        clk_in,
    input  wire                        rst_n,
    input  wire                        recv,
    input  wire                        mem_en,
    input  wire                        mem_wr,
    input  wire [`LSU_ROB_W-1:0]       cdb_rob_id,
    input  wire lsu_pkg::lsu_state_e   state
);
    import lsu_pkg::*;

    int fails = 0;   // Count of failed checks

    // Receive pulse is one cycle wide
    recv_single: assert property (@(posedge clk_in) disable iff (!rst_n)
        recv |=> !recv)
        else begin
            $error("recv high for two cycles in a row");
            fails++;
        end

    cdb_single: assert property (@(posedge clk_in) disable iff (!rst_n)
        (cdb_rob_id != '0) |=> (cdb_rob_id == '0))
        else begin
            $error("CDB tag held for more than one cycle");
            fails++;
        end

    wr_needs_en: assert property (@(posedge clk_in) disable iff (!rst_n)
        mem_wr |-> mem_en)
        else begin
            $error("mem_wr high without mem_en");
            fails++;
        end

    // Outputs quiet and FSM idle right after a reset cycle
    reset_state: assert property (@(posedge clk_in)
        !rst_n |=> (!mem_en && !recv && cdb_rob_id == '0 && state == ST_IDLE))
        else begin
            $error("unit not idle after reset");
            fails++;
        end

endmodule

bind lsu_ctrl lsu_assert u_assert (
    .clk_in     (clk_in),
    .rst_n      (rst_n),
    .recv       (recv),
    .mem_en     (mem_en),
    .mem_wr     (mem_wr),
    .cdb_rob_id (cdb_rob_id),
    .state      (state)
);

`default_nettype wire

//--- bench/tb_lsu.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_defs.svh"

module tb_lsu;
    import lsu_pkg::*;

    localparam int N_REQ           = 37;
    localparam int WATCHDOG_CYCLES = N_REQ * 200 + 10;

    logic        clk_in;
    logic        rst_n;
    logic        req_store;
    lsu_func3_e  req_op;
    logic [31:0] req_base;
    logic [31:0] req_data;
    logic [11:0] req_offset;
    logic [3:0]  req_dest;
    wire         recv;
    wire  [7:0]  mem_din;
    wire         mem_success;
    wire  [31:0] mem_addr;
    wire  [7:0]  mem_dout;
    wire         mem_wr;
    wire         mem_en;
    wire  [3:0]  cdb_rob_id;
    wire  [31:0] cdb_value;

    logic [7:0]  shadow [0:63];     // Expected memory contents
    logic [31:0] rand_state;
    logic [3:0]  next_tag;
    int          errors;
    int          issued;
    int          results;
    logic [3:0]  exp_tag_q [$];
    logic [31:0] exp_val_q [$];
    string       exp_name_q [$];
    logic [3:0]  want_tag;
    logic [31:0] want_val;
    string       want_name;
    logic        good;

    load_store_unit dut (
        .clk_in(clk_in), .rst_n(rst_n), .req_store(req_store), .req_op(req_op),
        .req_base(req_base), .req_data(req_data), .req_offset(req_offset),
        .req_dest(req_dest), .recv(recv), .mem_din(mem_din), .mem_success(mem_success),
        .mem_addr(mem_addr), .mem_dout(mem_dout), .mem_wr(mem_wr), .mem_en(mem_en),
        .cdb_rob_id(cdb_rob_id), .cdb_value(cdb_value)
    );

    mem_model u_mem (
        .clk_in(clk_in), .rst_n(rst_n), .mem_en(mem_en), .mem_wr(mem_wr),
        .mem_addr(mem_addr), .mem_dout(mem_dout), .mem_din(mem_din),
        .mem_success(mem_success)
    );

    always #50 clk_in = ~clk_in;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], rand_state[0]};
            rand_state = lfsr_next(rand_state);
        end
        return v;
    endfunction

    function automatic int access_size(input lsu_func3_e f);
        case (f)
            F3_LB_SB, F3_LBU: return 1;
            F3_LH_SH, F3_LHU: return 2;
            default:          return 4;
        endcase
    endfunction

    // Little-endian bytes at consecutive addresses, then extension by func3
    function logic [31:0] reference_result(input logic st, input lsu_func3_e f,
                                           input logic [31:0] addr, input logic [31:0] data);
        lsu_word_u   w;
        logic [31:0] v;
        logic [5:0]  idx;
        int          n;
        n      = access_size(f);
        w.word = data;
        if (st) begin
            for (int i = 0; i < n; i++) begin
                idx         = addr[5:0] + 6'(i);
                shadow[idx] = w.bytes[i];
            end
            return 32'h0;   // Stores report zero
        end
        w.word = '0;
        for (int i = 0; i < n; i++) begin
            idx        = addr[5:0] + 6'(i);
            w.bytes[i] = shadow[idx];
        end
        case (f)
            F3_LB_SB: v = {{24{w.bytes[0][7]}}, w.bytes[0]};
            F3_LBU:   v = {24'h0, w.bytes[0]};
            F3_LH_SH: v = {{16{w.bytes[1][7]}}, w.bytes[1], w.bytes[0]};
            F3_LHU:   v = {16'h0, w.bytes[1], w.bytes[0]};
            default:  v = w.word;
        endcase
        return v;
    endfunction

    task run_req(input logic st, input lsu_func3_e f, input logic [31:0] base,
                 input logic [11:0] off, input logic [31:0] data, input string name);
        logic [31:0] addr;
        addr = base + {{20{off[11]}}, off};
        exp_tag_q.push_back(next_tag);
        exp_val_q.push_back(reference_result(st, f, addr, data));
        exp_name_q.push_back(name);
        issued = issued + 1;
        @(posedge clk_in);
        #1;
        req_store  = st;
        req_op     = f;
        req_base   = base;
        req_offset = off;
        req_data   = data;
        req_dest   = next_tag;
        do @(negedge clk_in); while (!recv);
        assert (mem_addr == addr) else begin
            $display("MISMATCH %0t: %s address %h, expected %h", $time, name, mem_addr, addr);
            errors = errors + 1;
        end
        @(posedge clk_in);
        #1;
        req_dest = '0;   // Request leaves after recv
        next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        while (results < issued) @(negedge clk_in);
    endtask

    // Compare each CDB result against the oldest expected one
    always @(negedge clk_in) begin
        if (rst_n && cdb_rob_id != '0) begin
            if (exp_tag_q.size() == 0) begin
                $display("Unexpected CDB result with tag %0d at time %0t", cdb_rob_id, $time);
                errors = errors + 1;
            end else begin
                want_tag  = exp_tag_q.pop_front();
                want_val  = exp_val_q.pop_front();
                want_name = exp_name_q.pop_front();
                good      = 1'b1;
                assert (cdb_rob_id == want_tag) else begin
                    $display("MISMATCH %0t: %s tag %0d, expected %0d",
                             $time, want_name, cdb_rob_id, want_tag);
                    errors = errors + 1;
                    good   = 1'b0;
                end
                assert (cdb_value == want_val) else begin
                    $display("MISMATCH %0t: %s value %h, expected %h",
                             $time, want_name, cdb_value, want_val);
                    errors = errors + 1;
                    good   = 1'b0;
                end
                $display("%s tag %0d value %h: %s", want_name, cdb_rob_id, cdb_value,
                         good ? "ok" : "wrong");
                results = results + 1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        lsu_func3_e  store_ops [3];
        lsu_func3_e  load_ops  [5];
        logic        st;
        lsu_func3_e  f;
        int          pick;
        logic [31:0] word_a;
        store_ops  = '{F3_LB_SB, F3_LH_SH, F3_LW_SW};
        load_ops   = '{F3_LB_SB, F3_LH_SH, F3_LW_SW, F3_LBU, F3_LHU};
        clk_in     = 1'b0;
        rst_n      = 1'b0;
        req_store  = 1'b0;
        req_op     = F3_LB_SB;
        req_base   = '0;
        req_data   = '0;
        req_offset = '0;
        req_dest   = '0;
        rand_state = 32'h37e22db3;
        next_tag   = 4'd1;
        errors     = 0;
        issued     = 0;
        results    = 0;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = 8'(i * 29 + 7);   // Same fill as the memory model
        end
        repeat (10) @(posedge clk_in);
        #1;
        rst_n = 1'b1;

        // Word round trip
        word_a = take_bits(32);
        run_req(1'b1, F3_LW_SW, 32'h100, 12'h008, word_a, "sw word");
        run_req(1'b0, F3_LW_SW, 32'h100, 12'h008, 32'h0, "lw word");

        // Extension with top bit set and clear
        run_req(1'b1, F3_LW_SW, 32'd40, 12'h000, 32'h7f80ff01, "sw pattern");
        run_req(1'b0, F3_LB_SB, 32'd40, 12'h000, 32'h0, "lb clear");
        run_req(1'b0, F3_LB_SB, 32'd40, 12'h001, 32'h0, "lb set");
        run_req(1'b0, F3_LBU,   32'd40, 12'h001, 32'h0, "lbu set");
        run_req(1'b0, F3_LH_SH, 32'd40, 12'h001, 32'h0, "lh set");
        run_req(1'b0, F3_LHU,   32'd40, 12'h001, 32'h0, "lhu set");
        run_req(1'b0, F3_LH_SH, 32'd40, 12'h002, 32'h0, "lh clear");
        run_req(1'b0, F3_LHU,   32'd40, 12'h000, 32'h0, "lhu low");

        // Partial stores leave neighbours alone
        run_req(1'b1, F3_LW_SW, 32'd20, 12'h000, take_bits(32), "sw at 20");
        run_req(1'b1, F3_LW_SW, 32'd24, 12'h000, take_bits(32), "sw at 24");
        run_req(1'b1, F3_LB_SB, 32'd20, 12'h001, 32'hdeadbec3, "sb at 21");
        run_req(1'b1, F3_LH_SH, 32'd20, 12'h003, 32'h1234a55a, "sh at 23");
        run_req(1'b0, F3_LW_SW, 32'd20, 12'h000, 32'h0, "lw at 20");
        run_req(1'b0, F3_LW_SW, 32'd24, 12'h000, 32'h0, "lw at 24");
        run_req(1'b0, F3_LH_SH, 32'd20, 12'h003, 32'h0, "lh at 23");

        // Random mix under random stalls
        for (int i = 0; i < 16; i++) begin
            st = 1'(take_bits(1));
            if (st) begin
                pick = int'(take_bits(2)) % 3;
                f    = store_ops[pick];
            end else begin
                pick = int'(take_bits(3)) % 5;
                f    = load_ops[pick];
            end
            run_req(st, f, take_bits(32), 12'(take_bits(12)), take_bits(32),
                    $sformatf("random %0d", i));
        end

        // Negative offsets against positive ones
        run_req(1'b1, F3_LW_SW, 32'h40, 12'hffc, take_bits(32), "sw offset -4");
        run_req(1'b0, F3_LW_SW, 32'h30, 12'h00c, 32'h0, "lw offset 12");
        run_req(1'b1, F3_LH_SH, 32'h210, 12'hf01, take_bits(32), "sh offset -255");
        run_req(1'b0, F3_LHU,   32'h100, 12'h011, 32'h0, "lhu offset 17");

        repeat (5) @(negedge clk_in);
        if (dut.u_ctrl.u_assert.fails != 0) begin
            $display("Bound assertions failed %0d times", dut.u_ctrl.u_assert.fails);
            errors = errors + dut.u_ctrl.u_assert.fails;
        end
        $display("Requests %0d, results %0d, errors %0d", issued, results, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/lsu_pkg.sv
lsu/lsu_ctrl.sv
lsu/lsu_data.sv
lsu/load_store_unit.sv
bench/mem_model.sv
bench/lsu_assert.sv
bench/tb_lsu.sv

//--- Makefile
# Verilator build and run of the load/store unit testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_lsu
FILELIST  = verilog.f
LOG       = sim.log
PASS_TEXT = Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "test: pass" || \
		(echo "test: fail, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
